// ==== source/bcfg_pkg.sv ====
//----------------------------------------------------------
// Board configuration package
// Register map, EEPROM opcodes, bus structs and the
// host command word with its two views
//----------------------------------------------------------
package bcfg_pkg;

    //----------------------------------------------------------
    // Register map
    //----------------------------------------------------------
    localparam logic [3:0] addr_main       = 4'd0;   // Main register space
    localparam logic [3:0] addr_prom       = 4'd11;  // EEPROM space

    localparam logic [3:0] reg_status      = 4'd0;
    localparam logic [3:0] reg_version     = 4'd1;
    localparam logic [3:0] reg_bootcfg     = 4'd2;
    localparam logic [3:0] reg_prom_cmd    = 4'd0;   // Writable
    localparam logic [3:0] reg_prom_result = 4'd2;

    localparam logic [31:0] version_word = 32'h42434647;  // "BCFG"
    localparam int          boot_bytes   = 4;             // Config bytes at boot
    localparam int          sample_depth = 4;             // Sample buffer entries

    // 25AA128 instruction set subset
    localparam logic [7:0] op_read  = 8'h03;
    localparam logic [7:0] op_write = 8'h02;
    localparam logic [7:0] op_wren  = 8'h06;
    localparam logic [7:0] op_rdsr  = 8'h05;

    // Frame lengths on the wire
    localparam int bits_wren = 8;    // Opcode only
    localparam int bits_rdsr = 16;   // Opcode and status byte
    localparam int bits_addr = 32;   // Opcode, address, data

    //----------------------------------------------------------
    // Types
    //----------------------------------------------------------
    typedef struct packed {
        logic [15:0] raddr;
        logic [15:0] waddr;
        logic [31:0] wdata;
        logic        wen;
        logic [5:0]  sample_raddr;
        logic [3:0]  board_id;      // Rotary switch
        logic        sample_start;
        logic [4:0]  spare;         // Tied to zero
    } reg_bus_t;

    typedef struct packed {
        logic [7:0]  opcode;
        logic [15:0] addr;
        logic [7:0]  wdata;
    } prom_cmd_addr_t;

    typedef struct packed {
        logic [7:0]  opcode;
        logic [23:0] unused;
    } prom_cmd_bare_t;

    // One command word, decoded by opcode
    typedef union packed {
        prom_cmd_addr_t addr_view;  // READ and WRITE
        prom_cmd_bare_t bare_view;  // WREN and RDSR
    } prom_cmd_u;

    typedef struct packed {
        logic      start;  // Level, held until done
        prom_cmd_u cmd;
    } prom_req_t;

    typedef struct packed {
        logic       busy;
        logic       done;   // One-cycle pulse
        logic [7:0] rdata;  // Last byte shifted in
    } prom_rsp_t;

endpackage

// ==== source/spi_prom_engine.sv ====
//----------------------------------------------------------
// SPI EEPROM engine
// Runs one 25AA128 instruction per request, sclk at sysclk/4
//----------------------------------------------------------
module spi_prom_engine (
    input  logic                sysclk,
    input  logic                arst_n,
    input  bcfg_pkg::prom_req_t req,
    output bcfg_pkg::prom_rsp_t rsp,
    output logic                prom_sclk,
    output logic                prom_mosi,
    input  logic                prom_miso,
    output logic                prom_cs_n
);

    typedef enum logic [1:0] {
        st_idle,
        st_shift,
        st_finish
    } state_t;

    state_t      state_q;
    logic [1:0]  div_q;      // Phase within one sclk period
    logic [5:0]  bits_q;     // Bits still to go
    logic [31:0] tx_q;       // Outgoing frame, MSB first
    logic [7:0]  rx_q;       // Incoming byte
    logic [5:0]  cmd_bits;
    logic [31:0] cmd_frame;

    //----------------------------------------------------------
    // Command decode
    //----------------------------------------------------------
    always_comb begin
        case (req.cmd.bare_view.opcode)
            bcfg_pkg::op_wren: begin
                cmd_bits  = 6'(bcfg_pkg::bits_wren);
                cmd_frame = {req.cmd.bare_view.opcode, 24'd0};
            end
            bcfg_pkg::op_rdsr: begin
                cmd_bits  = 6'(bcfg_pkg::bits_rdsr);
                cmd_frame = {req.cmd.bare_view.opcode, 24'd0};  // Status comes back in slot 2
            end
            bcfg_pkg::op_read: begin
                cmd_bits  = 6'(bcfg_pkg::bits_addr);
                cmd_frame = {req.cmd.addr_view.opcode, req.cmd.addr_view.addr, 8'd0};
            end
            default: begin
                // WRITE and anything unknown take the addressed form
                cmd_bits  = 6'(bcfg_pkg::bits_addr);
                cmd_frame = {req.cmd.addr_view.opcode, req.cmd.addr_view.addr,
                             req.cmd.addr_view.wdata};
            end
        endcase
    end

    //----------------------------------------------------------
    // Sequencer
    //----------------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= st_idle;
            div_q     <= 2'd0;
            bits_q    <= 6'd0;
            prom_sclk <= 1'b0;
            prom_cs_n <= 1'b1;
        end else begin
            case (state_q)
                st_idle: begin
                    if (req.start) begin
                        state_q   <= st_shift;
                        prom_cs_n <= 1'b0;     // Select one cycle after start
                        div_q     <= 2'd0;
                        bits_q    <= cmd_bits;
                    end
                end
                st_shift: begin
                    div_q <= div_q + 2'd1;
                    if (div_q == 2'd1) begin
                        prom_sclk <= 1'b1;     // Rising edge
                    end else if (div_q == 2'd3) begin
                        prom_sclk <= 1'b0;     // Falling edge
                        bits_q    <= bits_q - 6'd1;
                        if (bits_q == 6'd1) begin
                            prom_cs_n <= 1'b1; // Last bit out
                            state_q   <= st_finish;
                        end
                    end
                end
                st_finish: state_q <= st_idle;  // Done pulse
                default:   state_q <= st_idle;
            endcase
        end
    end

    // Shift registers
    always_ff @(posedge sysclk) begin
        if (state_q == st_idle && req.start) begin
            tx_q <= cmd_frame;
        end else if (state_q == st_shift && div_q == 2'd3) begin
            tx_q <= {tx_q[30:0], 1'b0};        // Next bit on falling sclk
        end
        if (state_q == st_shift && div_q == 2'd1) begin
            rx_q <= {rx_q[6:0], prom_miso};    // Sample on rising sclk
        end
    end

    assign prom_mosi = tx_q[31] & ~prom_cs_n;  // Quiet while deselected

    always_comb begin
        rsp.busy  = (state_q == st_shift);
        rsp.done  = (state_q == st_finish);
        rsp.rdata = rx_q;
    end

endmodule

// ==== source/prom_arbiter.sv ====
//----------------------------------------------------------
// EEPROM arbiter
// Fixed priority, boot loader first, grant held per command
//----------------------------------------------------------
module prom_arbiter (
    input  logic                sysclk,
    input  logic                arst_n,
    input  bcfg_pkg::prom_req_t boot_req,
    input  bcfg_pkg::prom_req_t host_req,
    output bcfg_pkg::prom_req_t eng_req,
    input  bcfg_pkg::prom_rsp_t eng_rsp,
    output bcfg_pkg::prom_rsp_t boot_rsp,
    output bcfg_pkg::prom_rsp_t host_rsp
);

    logic owner_boot_q;  // 1 -> boot loader owns engine
    logic lock;
    logic grant_boot;

    // Busy plus the done cycle
    assign lock       = eng_rsp.busy | eng_rsp.done;
    assign grant_boot = lock ? owner_boot_q : boot_req.start;

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            owner_boot_q <= 1'b0;
        end else if (!lock) begin
            owner_boot_q <= grant_boot;  // Follow free grant until engine starts
        end
    end

    assign eng_req = grant_boot ? boot_req : host_req;

    //----------------------------------------------------------
    // Response steering
    //----------------------------------------------------------
    always_comb begin
        boot_rsp.busy  = eng_rsp.busy & grant_boot;
        boot_rsp.done  = eng_rsp.done & grant_boot;
        boot_rsp.rdata = eng_rsp.rdata;
        host_rsp.busy  = eng_rsp.busy & ~grant_boot;
        host_rsp.done  = eng_rsp.done & ~grant_boot;
        host_rsp.rdata = eng_rsp.rdata;
    end

endmodule

// ==== source/boot_loader.sv ====
//----------------------------------------------------------
// Boot loader
// Reads the configuration bytes from EEPROM address 0 up
// and assembles them into the boot configuration word
//----------------------------------------------------------
module boot_loader (
    input  logic                sysclk,
    input  logic                arst_n,
    output bcfg_pkg::prom_req_t req,
    input  bcfg_pkg::prom_rsp_t rsp,
    output logic                boot_done,
    output logic [31:0]         boot_word
);

    localparam int idx_w = $clog2(bcfg_pkg::boot_bytes);

    logic [idx_w-1:0] idx_q;    // Byte being fetched
    logic             start_q;

    //----------------------------------------------------------
    // Byte sequencing
    //----------------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            idx_q     <= '0;
            start_q   <= 1'b0;
            boot_done <= 1'b0;
            boot_word <= 32'd0;
        end else if (rsp.done) begin
            // New byte enters at the top, address 0 ends up lowest
            boot_word <= {rsp.rdata, boot_word[31:8]};
            idx_q     <= idx_q + 1'b1;
            if (idx_q == idx_w'(bcfg_pkg::boot_bytes - 1)) begin
                boot_done <= 1'b1;
                start_q   <= 1'b0;           // Release the engine
            end
        end else if (!boot_done) begin
            start_q <= 1'b1;                 // First cycle after reset
        end
    end

    // Read command for the current byte
    always_comb begin
        req.start                = start_q;
        req.cmd.addr_view.opcode = bcfg_pkg::op_read;
        req.cmd.addr_view.addr   = 16'(idx_q);
        req.cmd.addr_view.wdata  = 8'd0;
    end

endmodule

// ==== source/host_prom_port.sv ====
//----------------------------------------------------------
// Host EEPROM port
// Command register, pending flag and result register
//----------------------------------------------------------
module host_prom_port (
    input  logic                sysclk,
    input  logic                arst_n,
    input  logic                cmd_wr,
    input  bcfg_pkg::prom_cmd_u cmd_word,
    output bcfg_pkg::prom_req_t req,
    input  bcfg_pkg::prom_rsp_t rsp,
    output logic                pending,
    output logic [31:0]         result
);

    bcfg_pkg::prom_cmd_u cmd_q;  // Held for the whole command
    logic                accept;

    // New command only when idle
    assign accept = cmd_wr & ~pending;

    //----------------------------------------------------------
    // Pending flag and result
    //----------------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= 1'b0;
            result  <= 32'd0;
        end else begin
            if (accept) begin
                pending <= 1'b1;
            end else if (rsp.done) begin
                pending <= 1'b0;
                // Opcode above the returned byte
                result  <= {16'd0, cmd_q.bare_view.opcode, rsp.rdata};
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (accept) begin
            cmd_q <= cmd_word;
        end
    end

    always_comb begin
        req.start = pending;  // Level until done
        req.cmd   = cmd_q;
    end

endmodule

// ==== source/sample_capture.sv ====
//----------------------------------------------------------
// Sample capture
// Free-running timestamp and a small buffer for block reads
//----------------------------------------------------------
module sample_capture (
    input  logic        sysclk,
    input  logic        arst_n,
    input  logic        sample_start,
    input  logic [31:0] status_word,
    input  logic [5:0]  sample_raddr,
    output logic        sample_busy,
    output logic [31:0] sample_rdata,
    output logic [31:0] timestamp
);

    logic [31:0] entry_q [bcfg_pkg::sample_depth];
    logic        capture;

    // Rising start only
    assign capture = sample_start & ~sample_busy;

    //----------------------------------------------------------
    // Timestamp and buffer
    //----------------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            sample_busy <= 1'b0;
            timestamp   <= 32'd0;
            for (int i = 0; i < bcfg_pkg::sample_depth; i++) begin
                entry_q[i] <= 32'd0;
            end
        end else begin
            sample_busy <= sample_start;  // Clears a cycle after start drops
            if (capture) begin
                entry_q[0] <= timestamp;
                entry_q[1] <= status_word;
                timestamp  <= 32'd0;      // Restart at capture
            end else begin
                timestamp  <= timestamp + 32'd1;
            end
        end
    end

    // Entries 2 and 3 stay zero
    assign sample_rdata = entry_q[sample_raddr[1:0]];

endmodule

// ==== source/boot_config_top.sv ====
//----------------------------------------------------------
// Board configuration top level
// Register decode and read mux, status and version words,
// EEPROM path and sample buffer
//----------------------------------------------------------
module boot_config_top (
    input  logic               sysclk,
    input  logic               arst_n,
    input  bcfg_pkg::reg_bus_t bus,
    output logic [31:0]        reg_rdata,
    output logic               prom_sclk,
    output logic               prom_mosi,
    input  logic               prom_miso,
    output logic               prom_cs_n,
    output logic               sample_busy,
    output logic [31:0]        sample_rdata,
    output logic [31:0]        timestamp
);

    bcfg_pkg::prom_req_t boot_req;
    bcfg_pkg::prom_req_t host_req;
    bcfg_pkg::prom_req_t eng_req;
    bcfg_pkg::prom_rsp_t eng_rsp;
    bcfg_pkg::prom_rsp_t boot_rsp;
    bcfg_pkg::prom_rsp_t host_rsp;

    logic        boot_done;
    logic [31:0] boot_word;
    logic        host_pending;
    logic [31:0] host_result;
    logic        cmd_wr;
    logic [31:0] status_word;

    //----------------------------------------------------------
    // Write decode and status
    //----------------------------------------------------------
    assign cmd_wr = bus.wen
                  && (bus.waddr[15:12] == bcfg_pkg::addr_prom)
                  && (bus.waddr[3:0] == bcfg_pkg::reg_prom_cmd);

    // Board ID high, EEPROM state low
    assign status_word = {4'd0, bus.board_id, 22'd0, eng_rsp.busy, boot_done};

    // Read mux, combinational from raddr
    always_comb begin
        reg_rdata = 32'd0;
        if (bus.raddr[15:12] == bcfg_pkg::addr_main) begin
            case (bus.raddr[3:0])
                bcfg_pkg::reg_status:  reg_rdata = status_word;
                bcfg_pkg::reg_version: reg_rdata = bcfg_pkg::version_word;
                bcfg_pkg::reg_bootcfg: reg_rdata = boot_word;
                default:               reg_rdata = 32'd0;
            endcase
        end else if (bus.raddr[15:12] == bcfg_pkg::addr_prom
                     && bus.raddr[3:0] == bcfg_pkg::reg_prom_result) begin
            reg_rdata = host_result;
        end
    end

    //----------------------------------------------------------
    // Instances
    //----------------------------------------------------------
    boot_loader u_boot (
        .sysclk(sysclk), .arst_n(arst_n), .req(boot_req), .rsp(boot_rsp),
        .boot_done(boot_done), .boot_word(boot_word)
    );

    host_prom_port u_host (
        .sysclk(sysclk), .arst_n(arst_n), .cmd_wr(cmd_wr), .cmd_word(bus.wdata),
        .req(host_req), .rsp(host_rsp), .pending(host_pending), .result(host_result)
    );

    prom_arbiter u_arb (
        .sysclk(sysclk), .arst_n(arst_n), .boot_req(boot_req), .host_req(host_req),
        .eng_req(eng_req), .eng_rsp(eng_rsp), .boot_rsp(boot_rsp), .host_rsp(host_rsp)
    );

    spi_prom_engine u_engine (
        .sysclk(sysclk), .arst_n(arst_n), .req(eng_req), .rsp(eng_rsp),
        .prom_sclk(prom_sclk), .prom_mosi(prom_mosi), .prom_miso(prom_miso),
        .prom_cs_n(prom_cs_n)
    );

    sample_capture u_sample (
        .sysclk(sysclk), .arst_n(arst_n), .sample_start(bus.sample_start),
        .status_word(status_word), .sample_raddr(bus.sample_raddr),
        .sample_busy(sample_busy), .sample_rdata(sample_rdata), .timestamp(timestamp)
    );

endmodule

// ==== sim/prom_model.sv ====
//----------------------------------------------------------
// SPI EEPROM model
// 25AA128-style byte array with READ, WRITE, WREN and RDSR,
// SPI mode 0, write cycle completes instantly
//----------------------------------------------------------
module prom_model (
    input  logic prom_sclk,
    input  logic prom_mosi,
    output logic prom_miso,
    input  logic prom_cs_n
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int         depth    = 16384;  // 128 kbit
    localparam logic [7:0] i_read   = 8'h03;
    localparam logic [7:0] i_write  = 8'h02;
    localparam logic [7:0] i_wren   = 8'h06;
    localparam logic [7:0] i_rdsr   = 8'h05;

    logic [7:0]  mem [depth];   // Preloaded by the testbench
    logic        wel;           // Write-enable latch
    logic [5:0]  bit_cnt;       // Bits seen since select
    logic [7:0]  opcode;
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic [7:0]  out_byte;      // Shifts out on MISO
    logic [7:0]  status;

    assign status = {6'd0, wel, 1'b0};  // WIP never set

    initial begin
        wel       = 1'b0;
        bit_cnt   = 6'd0;
        opcode    = 8'd0;
        out_byte  = 8'd0;
        prom_miso = 1'b0;
    end

    // New instruction on select
    always @(negedge prom_cs_n) begin
        bit_cnt = 6'd0;
        opcode  = 8'd0;
    end

    //----------------------------------------------------------
    // Input side, MOSI sampled on rising sclk
    //----------------------------------------------------------
    always @(posedge prom_sclk) begin
        if (!prom_cs_n) begin
            if (bit_cnt < 6'd8) begin
                opcode = {opcode[6:0], prom_mosi};
            end else if (bit_cnt < 6'd24) begin
                addr = {addr[14:0], prom_mosi};
            end else begin
                wdata = {wdata[6:0], prom_mosi};
            end
            bit_cnt = bit_cnt + 6'd1;
        end
    end

    // Output side, next bit set up on falling sclk
    always @(negedge prom_sclk) begin
        if (!prom_cs_n) begin
            if (opcode == i_read && bit_cnt == 6'd24) begin
                out_byte = mem[addr[13:0]];
            end else if (opcode == i_rdsr && bit_cnt == 6'd8) begin
                out_byte = status;
            end else begin
                out_byte = {out_byte[6:0], 1'b0};
            end
            prom_miso = out_byte[7];
        end
    end

    // Instruction takes effect on deselect
    always @(posedge prom_cs_n) begin
        if (opcode == i_wren && bit_cnt == 6'd8) begin
            wel = 1'b1;
        end else if (opcode == i_write && bit_cnt == 6'd32 && wel) begin
            mem[addr[13:0]] = wdata;
            wel             = 1'b0;   // Latch clears after a write
        end
    end

endmodule

// ==== sim/boot_config_assertions.sv ====
//----------------------------------------------------------
// Protocol checks for the board configuration top level
// SPI select, done pulse, grant lock and sample busy
//----------------------------------------------------------
module boot_config_assertions (
    input logic                sysclk,
    input logic                arst_n,
    input bcfg_pkg::reg_bus_t  bus,
    input logic                prom_cs_n,
    input bcfg_pkg::prom_rsp_t eng_rsp,
    input bcfg_pkg::prom_rsp_t boot_rsp,
    input logic                sample_busy
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;  // Summed into the final verdict

    // Select only inside a transfer
    cs_idle_high: assert property (@(posedge sysclk) disable iff (!arst_n)
        !eng_rsp.busy |-> prom_cs_n)
        else begin
            fail_count++;
            $error("chip select low while the engine is idle");
        end

    // Done is the first cycle after busy
    done_with_busy: assert property (@(posedge sysclk) disable iff (!arst_n)
        eng_rsp.done |-> !eng_rsp.busy && $past(eng_rsp.busy))
        else begin
            fail_count++;
            $error("done pulse not aligned with busy falling");
        end

    // Owner visible through the steered busy bit
    grant_locked: assert property (@(posedge sysclk) disable iff (!arst_n)
        eng_rsp.busy && $past(eng_rsp.busy) |-> boot_rsp.busy == $past(boot_rsp.busy))
        else begin
            fail_count++;
            $error("grant changed during a transfer");
        end

    done_to_owner: assert property (@(posedge sysclk) disable iff (!arst_n)
        eng_rsp.done |-> boot_rsp.done == $past(boot_rsp.busy))
        else begin
            fail_count++;
            $error("done steered away from the owner");
        end

    sample_busy_follows: assert property (@(posedge sysclk) disable iff (!arst_n)
        sample_busy == $past(bus.sample_start))
        else begin
            fail_count++;
            $error("sample_busy does not follow sample_start");
        end

endmodule

// ==== sim/tb_boot_config.sv ====
//----------------------------------------------------------
// Board configuration testbench
// Register bus tasks, EEPROM model on the SPI pins,
// six directed tests, watchdog and summary
//----------------------------------------------------------
module tb_boot_config;

    timeunit 1ns;
    timeprecision 100ps;

    // About ten EEPROM commands of ~140 cycles each, wide margin
    localparam int max_cycles = 20000;
    localparam int prom_bytes = 16384;

    localparam logic [15:0] status_addr  = {bcfg_pkg::addr_main, 8'h00, bcfg_pkg::reg_status};
    localparam logic [15:0] version_addr = {bcfg_pkg::addr_main, 8'h00, bcfg_pkg::reg_version};
    localparam logic [15:0] bootcfg_addr = {bcfg_pkg::addr_main, 8'h00, bcfg_pkg::reg_bootcfg};
    localparam logic [15:0] cmd_addr     = {bcfg_pkg::addr_prom, 8'h00, bcfg_pkg::reg_prom_cmd};
    localparam logic [15:0] result_addr  = {bcfg_pkg::addr_prom, 8'h00,
                                            bcfg_pkg::reg_prom_result};

    logic               sysclk;
    logic               arst_n;
    bcfg_pkg::reg_bus_t bus;
    logic [31:0]        reg_rdata;
    logic               prom_sclk;
    logic               prom_mosi;
    logic               prom_miso;
    logic               prom_cs_n;
    logic               sample_busy;
    logic [31:0]        sample_rdata;
    logic [31:0]        timestamp;

    int cycles       = 0;
    int checks       = 0;
    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    boot_config_top uut (
        .sysclk(sysclk), .arst_n(arst_n), .bus(bus), .reg_rdata(reg_rdata),
        .prom_sclk(prom_sclk), .prom_mosi(prom_mosi), .prom_miso(prom_miso),
        .prom_cs_n(prom_cs_n), .sample_busy(sample_busy), .sample_rdata(sample_rdata),
        .timestamp(timestamp)
    );

    prom_model prom (
        .prom_sclk(prom_sclk), .prom_mosi(prom_mosi), .prom_miso(prom_miso),
        .prom_cs_n(prom_cs_n)
    );

    bind boot_config_top boot_config_assertions u_assert (
        .sysclk(sysclk), .arst_n(arst_n), .bus(bus), .prom_cs_n(prom_cs_n),
        .eng_rsp(eng_rsp), .boot_rsp(boot_rsp), .sample_busy(sample_busy)
    );

    initial begin
        sysclk = 1'b0;
        forever #2 sysclk = ~sysclk;  // 4 ns period
    end

    //----------------------------------------------------------
    // Helpers
    //----------------------------------------------------------
    function automatic int fail_total();
        return errors + uut.u_assert.fail_count;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR: %s", msg);
    endtask

    task automatic report_test(input string name, input int mark);
        tests_run++;
        if (fail_total() == mark) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d problems", name, fail_total() - mark);
        end
    endtask

    task automatic next_cycle();
        @(posedge sysclk);
        #1;                               // Drive just after the edge
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
        next_cycle();
        bus.waddr = addr;
        bus.wdata = data;
        bus.wen   = 1'b1;
        next_cycle();
        bus.wen   = 1'b0;                 // One-cycle strobe
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [31:0] data);
        next_cycle();
        bus.raddr = addr;
        @(negedge sysclk);                // Mid-cycle, mux settled
        data = reg_rdata;
    endtask

    task automatic wait_host_idle();
        while (uut.host_pending) begin
            @(negedge sysclk);
        end
    endtask

    task automatic host_command(input logic [31:0] word);
        bus_write(cmd_addr, word);
        wait_host_idle();
    endtask

    // Watchdog
    initial begin
        while (cycles < max_cycles) begin
            @(posedge sysclk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", max_cycles);
        $display("TEST FAIL");
        $finish;
    end

    //----------------------------------------------------------
    // Test sequence
    //----------------------------------------------------------
    initial begin
        logic [31:0] rd;
        logic [31:0] ts_before;
        logic [31:0] exp_status;
        logic [15:0] host_addr;
        logic [15:0] wr_addr;
        logic [7:0]  wr_data;
        logic [3:0]  ids [3];
        logic        early_done;
        int          mark;
        int          rst_cycle;

        bus    = '0;
        arst_n = 1'b0;
        void'($urandom(53));              // Single seed for the run
        for (int i = 0; i < prom_bytes; i++) begin
            prom.mem[i] = 8'($urandom);
        end
        prom.mem[0] = 8'h11;              // Boot bytes
        prom.mem[1] = 8'h22;
        prom.mem[2] = 8'h33;
        prom.mem[3] = 8'h44;
        repeat (3) @(posedge sysclk);
        #1 arst_n = 1'b1;
        rst_cycle = cycles;               // Timestamp counts edges from here

        // Host read straight after reset, boot loader must win
        mark       = fail_total();
        early_done = 1'b0;
        host_addr  = 16'(16 + ($urandom % (prom_bytes - 16)));
        bus_write(cmd_addr, {bcfg_pkg::op_read, host_addr, 8'h00});
        bus.raddr = status_addr;
        @(negedge sysclk);
        while (reg_rdata[0] == 1'b0) begin
            if (!uut.host_pending) early_done = 1'b1;
            @(negedge sysclk);
        end
        if (early_done || !uut.host_pending) begin
            report_error("host command completed before boot_done was set");
        end
        wait_host_idle();
        bus_read(result_addr, rd);
        check_value("prom_result", rd, {16'd0, bcfg_pkg::op_read, prom.mem[host_addr[13:0]]});
        report_test("host_waits_for_boot", mark);

        // Version and unmapped space
        mark = fail_total();
        bus_read(version_addr, rd);
        check_value("version", rd, "BCFG");
        bus_read(16'h0003, rd);
        check_value("unmapped_0003", rd, 32'd0);
        bus_read(16'h000F, rd);
        check_value("unmapped_000f", rd, 32'd0);
        bus_read(16'hB001, rd);
        check_value("unmapped_b001", rd, 32'd0);
        bus_read(16'h5002, rd);
        check_value("unmapped_5002", rd, 32'd0);
        report_test("version_unmapped", mark);

        // Board ID in the status word
        mark   = fail_total();
        ids[0] = 4'h3;
        ids[1] = 4'hC;
        ids[2] = 4'h9;
        for (int i = 0; i < 3; i++) begin
            next_cycle();
            bus.board_id = ids[i];
            bus_read(status_addr, rd);
            check_value("status", rd, {4'd0, ids[i], 22'd0, 1'b0, 1'b1});
        end
        report_test("status_board_id", mark);

        // Boot word, address 0 lowest
        mark = fail_total();
        bus_read(bootcfg_addr, rd);
        check_value("bootcfg", rd, 32'h44332211);
        report_test("boot_config_word", mark);

        // Write then read back, then status register
        mark    = fail_total();
        wr_addr = 16'(16 + ($urandom % (prom_bytes - 16)));
        wr_data = 8'($urandom);
        if (wr_data == prom.mem[wr_addr[13:0]]) wr_data = ~wr_data;
        host_command({bcfg_pkg::op_wren, 24'd0});
        host_command({bcfg_pkg::op_write, wr_addr, wr_data});
        check_value("prom_mem", 32'(prom.mem[wr_addr[13:0]]), 32'(wr_data));
        host_command({bcfg_pkg::op_read, wr_addr, 8'h00});
        bus_read(result_addr, rd);
        check_value("prom_result", rd, {16'd0, bcfg_pkg::op_read, wr_data});
        host_command({bcfg_pkg::op_wren, 24'd0});
        host_command({bcfg_pkg::op_rdsr, 24'd0});
        bus_read(result_addr, rd);
        check_value("prom_result", rd, {16'd0, bcfg_pkg::op_rdsr, prom.status});
        check_value("prom_status", 32'(prom.status), 32'h02);  // WEL set by WREN
        report_test("host_write_read_rdsr", mark);

        // Sample capture
        mark = fail_total();
        next_cycle();
        bus.board_id     = 4'hA;
        bus.raddr        = status_addr;
        bus.sample_start = 1'b1;
        @(negedge sysclk);
        ts_before  = 32'(cycles - rst_cycle);  // Edges since reset release
        exp_status = {4'd0, 4'hA, 22'd0, 1'b0, 1'b1};
        check_value("timestamp", timestamp, ts_before);
        check_value("status", reg_rdata, exp_status);
        @(negedge sysclk);
        check_value("timestamp", timestamp, 32'd0);
        next_cycle();
        bus.sample_start = 1'b0;
        bus.sample_raddr = 6'd0;
        @(negedge sysclk);
        check_value("sample_entry0", sample_rdata, ts_before);
        next_cycle();
        bus.sample_raddr = 6'd1;
        @(negedge sysclk);
        check_value("sample_entry1", sample_rdata, exp_status);
        next_cycle();
        bus.sample_raddr = 6'd2;
        @(negedge sysclk);
        check_value("sample_entry2", sample_rdata, 32'd0);
        repeat (2) next_cycle();
        report_test("sample_capture", mark);

        $display("tests=%0d failed=%0d checks=%0d errors=%0d assertion_failures=%0d",
                 tests_run, tests_failed, checks, errors, uut.u_assert.fail_count);
        if (fail_total() == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== project.f ====
source/bcfg_pkg.sv
source/spi_prom_engine.sv
source/prom_arbiter.sv
source/boot_loader.sv
source/host_prom_port.sv
source/sample_capture.sv
source/boot_config_top.sv
sim/prom_model.sv
sim/boot_config_assertions.sv
sim/tb_boot_config.sv

// ==== Bender.yml ====
package:
  name: boot_config

sources:
  - files:
      - source/bcfg_pkg.sv
      - source/spi_prom_engine.sv
      - source/prom_arbiter.sv
      - source/boot_loader.sv
      - source/host_prom_port.sv
      - source/sample_capture.sv
      - source/boot_config_top.sv
  - target: simulation
    files:
      - sim/prom_model.sv
      - sim/boot_config_assertions.sv
      - sim/tb_boot_config.sv
